/* decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // opcode field values
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field values under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // rt field values under op_regimm
    localparam logic [4:0] rt_bltz   = 5'h00;
    localparam logic [4:0] rt_bgez   = 5'h01;
    localparam logic [4:0] rt_bltzal = 5'h10;
    localparam logic [4:0] rt_bgezal = 5'h11;

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_none, src1_rs, src1_pc, src1_shamt
    } src1_sel_e;

    typedef enum logic [2:0] {
        src2_none, src2_rt, src2_imm_sign, src2_imm_zero, src2_const_eight
    } src2_sel_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz,
        br_bltzal, br_bgezal, br_j, br_jal, br_jr, br_jalr
    } branch_kind_e;

    typedef struct packed {
        logic  ce;
        word_t pc;
        word_t inst;
    } fetch_t;

    // forward and write-back record
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      mem_en;
        logic [3:0] mem_wen;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      load_result;
        word_t     rdata1;
        word_t     rdata2;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

/* decode_latch.sv */
`timescale 1ns/10ps

module decode_latch
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   stall_id,
    input  logic   stall_ex,
    input  fetch_t fetch,
    output fetch_t held
);

    fetch_t latch_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            latch_q <= '0;
        end else if (stall_id && !stall_ex) begin
            // decode stuck but execute moves on, so feed it a bubble
            latch_q <= '0;
        end else if (stall_id) begin
            latch_q <= latch_q;
        end else begin
            latch_q <= fetch;
        end
    end

    assign held = latch_q;

endmodule

/* inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder
    import decode_pkg::*;
(
    input  fetch_t       cur,
    output reg_addr_t    rs,
    output reg_addr_t    rt,
    output id_ex_t       ctrl,
    output branch_kind_e kind,
    output logic [15:0]  offset16,
    output logic [25:0]  index26
);

    logic [5:0]   opcode;
    logic [5:0]   funct;
    reg_addr_t    rd;
    logic [4:0]   sa;
    alu_op_e      alu_op;
    src1_sel_e    src1_sel;
    src2_sel_e    src2_sel;
    logic         rf_we;
    reg_addr_t    rf_waddr;
    logic         mem_en;
    logic [3:0]   mem_wen;
    logic         load_result;
    branch_kind_e br_kind;

    // register-type funct to alu op, none for anything unknown
    function automatic alu_op_e funct_alu(input logic [5:0] f);
        case (f)
            fn_add, fn_addu:  return alu_add;
            fn_sub, fn_subu:  return alu_sub;
            fn_slt:           return alu_slt;
            fn_sltu:          return alu_sltu;
            fn_and:           return alu_and;
            fn_or:            return alu_or;
            fn_xor:           return alu_xor;
            fn_nor:           return alu_nor;
            fn_sll, fn_sllv:  return alu_sll;
            fn_srl, fn_srlv:  return alu_srl;
            fn_sra, fn_srav:  return alu_sra;
            default:          return alu_none;
        endcase
    endfunction

    assign opcode   = cur.inst[31:26];
    assign rs       = cur.inst[25:21];
    assign rt       = cur.inst[20:16];
    assign rd       = cur.inst[15:11];
    assign sa       = cur.inst[10:6];
    assign funct    = cur.inst[5:0];
    assign offset16 = cur.inst[15:0];
    assign index26  = cur.inst[25:0];

    always_comb begin
        br_kind     = br_none;
        alu_op      = alu_none;
        src1_sel    = src1_none;
        src2_sel    = src2_none;
        rf_we       = 1'b0;
        rf_waddr    = '0;
        mem_en      = 1'b0;
        mem_wen     = 4'b0000;
        load_result = 1'b0;
        if (cur.ce) begin
            case (opcode)
                op_special: begin
                    case (funct)
                        fn_sll, fn_srl, fn_sra: begin
                            if (rs == 5'd0) begin
                                alu_op   = funct_alu(funct);
                                src1_sel = src1_shamt;
                                src2_sel = src2_rt;
                                rf_we    = 1'b1;
                                rf_waddr = rd;
                            end
                        end
                        fn_jr: begin
                            if (sa == 5'd0 && cur.inst[20:11] == 10'd0) begin
                                br_kind = br_jr;
                            end
                        end
                        fn_jalr: begin
                            if (sa == 5'd0 && rt == 5'd0) begin
                                br_kind = br_jalr;
                            end
                        end
                        default: begin
                            if (sa == 5'd0 && funct_alu(funct) != alu_none) begin
                                alu_op   = funct_alu(funct);
                                src1_sel = src1_rs;
                                src2_sel = src2_rt;
                                rf_we    = 1'b1;
                                rf_waddr = rd;
                            end
                        end
                    endcase
                end
                op_regimm: begin
                    case (rt)
                        rt_bltz:   br_kind = br_bltz;
                        rt_bgez:   br_kind = br_bgez;
                        rt_bltzal: br_kind = br_bltzal;
                        rt_bgezal: br_kind = br_bgezal;
                        default:   br_kind = br_none;
                    endcase
                end
                op_j:   br_kind = br_j;
                op_jal: br_kind = br_jal;
                op_beq: br_kind = br_beq;
                op_bne: br_kind = br_bne;
                op_blez: begin
                    if (rt == 5'd0) begin
                        br_kind = br_blez;
                    end
                end
                op_bgtz: begin
                    if (rt == 5'd0) begin
                        br_kind = br_bgtz;
                    end
                end
                op_addi, op_addiu: begin
                    alu_op   = alu_add;
                    src2_sel = src2_imm_sign;
                end
                op_slti: begin
                    alu_op   = alu_slt;
                    src2_sel = src2_imm_sign;
                end
                op_sltiu: begin
                    alu_op   = alu_sltu;
                    src2_sel = src2_imm_sign;
                end
                op_andi: begin
                    alu_op   = alu_and;
                    src2_sel = src2_imm_zero;
                end
                op_ori: begin
                    alu_op   = alu_or;
                    src2_sel = src2_imm_zero;
                end
                op_xori: begin
                    alu_op   = alu_xor;
                    src2_sel = src2_imm_zero;
                end
                op_lui: begin
                    alu_op   = alu_lui;
                    src2_sel = src2_imm_sign;
                end
                op_lw: begin
                    alu_op      = alu_add;
                    src2_sel    = src2_imm_sign;
                    mem_en      = 1'b1;
                    load_result = 1'b1;
                end
                op_sw: begin
                    alu_op   = alu_add;
                    src2_sel = src2_imm_sign;
                    mem_en   = 1'b1;
                    mem_wen  = 4'b1111;
                end
                default: ;
            endcase

            // immediate forms read rs and write rt, lui has no rs, sw no write
            if (src2_sel == src2_imm_sign || src2_sel == src2_imm_zero) begin
                if (opcode != op_lui) begin
                    src1_sel = src1_rs;
                end
                if (opcode != op_sw) begin
                    rf_we    = 1'b1;
                    rf_waddr = rt;
                end
            end

            // link forms compute pc + 8 in execute
            if (br_kind inside {br_jal, br_bltzal, br_bgezal, br_jalr}) begin
                alu_op   = alu_add;
                src1_sel = src1_pc;
                src2_sel = src2_const_eight;
                rf_we    = 1'b1;
                rf_waddr = (br_kind == br_jalr) ? rd : 5'd31;
            end
        end
    end

    always_comb begin
        ctrl             = '0;
        ctrl.pc          = cur.pc;
        ctrl.inst        = cur.inst;
        ctrl.alu_op      = alu_op;
        ctrl.src1_sel    = src1_sel;
        ctrl.src2_sel    = src2_sel;
        ctrl.mem_en      = mem_en;
        ctrl.mem_wen     = mem_wen;
        ctrl.rf_we       = rf_we;
        ctrl.rf_waddr    = rf_waddr;
        ctrl.load_result = load_result;
    end

    assign kind = br_kind;

endmodule

/* operand_read.sv */
`timescale 1ns/10ps

module operand_read
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  rf_write_t ex_fwd,
    input  rf_write_t mem_fwd,
    input  rf_write_t wb_fwd,
    input  rf_write_t wb_write,
    input  logic      ex_load,
    output word_t     rdata1,
    output word_t     rdata2,
    output logic      stall_req
);

    word_t regs [32];

    // youngest result wins, r0 is hardwired
    function automatic word_t read_port(
        input reg_addr_t addr,
        input word_t     stored,
        input rf_write_t ex_r,
        input rf_write_t mem_r,
        input rf_write_t wb_r
    );
        if (addr == 5'd0) begin
            return '0;
        end
        if (ex_r.we && ex_r.addr == addr) begin
            return ex_r.data;
        end
        if (mem_r.we && mem_r.addr == addr) begin
            return mem_r.data;
        end
        if (wb_r.we && wb_r.addr == addr) begin
            return wb_r.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.we && wb_write.addr != 5'd0) begin
            regs[wb_write.addr] <= wb_write.data;
        end
    end

    assign rdata1 = read_port(rs, regs[rs], ex_fwd, mem_fwd, wb_fwd);
    assign rdata2 = read_port(rt, regs[rt], ex_fwd, mem_fwd, wb_fwd);

    // load in execute has no data yet for a dependent read
    assign stall_req = ex_load && ((ex_fwd.addr == rs) || (ex_fwd.addr == rt));

endmodule

/* branch_resolve.sv */
`timescale 1ns/10ps

module branch_resolve
    import decode_pkg::*;
(
    input  word_t        pc,
    input  branch_kind_e kind,
    input  logic [15:0]  offset16,
    input  logic [25:0]  index26,
    input  word_t        rdata1,
    input  word_t        rdata2,
    output branch_t      branch
);

    word_t pc_plus_4;
    word_t rel_target;
    word_t region_target;
    logic  rs_neg;
    logic  rs_zero;

    assign pc_plus_4     = pc + 32'd4;
    assign rel_target    = pc_plus_4 + {{14{offset16[15]}}, offset16, 2'b00};
    assign region_target = {pc_plus_4[31:28], index26, 2'b00};

    assign rs_neg  = rdata1[31];
    assign rs_zero = (rdata1 == 32'd0);

    always_comb begin
        branch.taken  = 1'b0;
        branch.target = '0;
        case (kind)
            br_beq: begin
                branch.taken  = (rdata1 == rdata2);
                branch.target = rel_target;
            end
            br_bne: begin
                branch.taken  = (rdata1 != rdata2);
                branch.target = rel_target;
            end
            br_bgez, br_bgezal: begin
                branch.taken  = !rs_neg;
                branch.target = rel_target;
            end
            br_bltz, br_bltzal: begin
                branch.taken  = rs_neg;
                branch.target = rel_target;
            end
            br_bgtz: begin
                branch.taken  = !rs_neg && !rs_zero;
                branch.target = rel_target;
            end
            br_blez: begin
                branch.taken  = rs_neg || rs_zero;
                branch.target = rel_target;
            end
            br_j, br_jal: begin
                branch.taken  = 1'b1;
                branch.target = region_target;
            end
            br_jr, br_jalr: begin
                branch.taken  = 1'b1;
                branch.target = rdata1;
            end
            default: ;
        endcase
    end

endmodule

/* id_stage.sv */
`timescale 1ns/10ps

module id_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  fetch_t    fetch,
    input  logic      stall_id,
    input  logic      stall_ex,
    input  rf_write_t ex_fwd,
    input  rf_write_t mem_fwd,
    input  rf_write_t wb_fwd,
    input  rf_write_t wb_write,
    input  logic      ex_load,
    output id_ex_t    id_ex,
    output branch_t   branch,
    output logic      stall_req
);

    fetch_t       held;
    reg_addr_t    rs;
    reg_addr_t    rt;
    id_ex_t       dec_ctrl;
    branch_kind_e kind;
    logic [15:0]  offset16;
    logic [25:0]  index26;
    word_t        rdata1;
    word_t        rdata2;

    decode_latch i_latch (
        .clk      (clk),
        .rst      (rst),
        .stall_id (stall_id),
        .stall_ex (stall_ex),
        .fetch    (fetch),
        .held     (held)
    );

    inst_decoder i_decoder (
        .cur      (held),
        .rs       (rs),
        .rt       (rt),
        .ctrl     (dec_ctrl),
        .kind     (kind),
        .offset16 (offset16),
        .index26  (index26)
    );

    operand_read i_operands (
        .clk       (clk),
        .rst       (rst),
        .rs        (rs),
        .rt        (rt),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .wb_write  (wb_write),
        .ex_load   (ex_load),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .stall_req (stall_req)
    );

    branch_resolve i_branch (
        .pc       (held.pc),
        .kind     (kind),
        .offset16 (offset16),
        .index26  (index26),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .branch   (branch)
    );

    // decoder leaves the operand fields empty
    always_comb begin
        id_ex        = dec_ctrl;
        id_ex.rdata1 = rdata1;
        id_ex.rdata2 = rdata2;
    end

endmodule

/* tb_id_stage.sv */
`timescale 1ns/10ps

module tb_id_stage;
    import decode_pkg::*;

    localparam int clk_period = 100;
    // cycle budget per test, rounded up
    localparam int reset_cycles   = 8;
    localparam int decode_cycles  = 7 * 2;
    localparam int operand_cycles = 33 + 8 * 2 + 12;
    localparam int branch_cycles  = 12 * 3 * 4;
    localparam int hold_cycles    = 12;
    localparam int load_cycles    = 12;
    localparam int margin_cycles  = 100;
    localparam int total_cycles   = reset_cycles + decode_cycles + operand_cycles
                                  + branch_cycles + hold_cycles + load_cycles + margin_cycles;

    typedef struct packed {
        word_t      inst;
        alu_op_e    alu;
        src1_sel_e  s1;
        src2_sel_e  s2;
        logic       we;
        reg_addr_t  waddr;
        logic       men;
        logic [3:0] wen;
        logic       lr;
    } dec_row_t;

    logic      clk;
    logic      rst;
    fetch_t    fetch;
    logic      stall_id;
    logic      stall_ex;
    rf_write_t ex_fwd;
    rf_write_t mem_fwd;
    rf_write_t wb_fwd;
    rf_write_t wb_write;
    logic      ex_load;
    id_ex_t    id_ex;
    branch_t   branch;
    logic      stall_req;

    int          error_count;
    int          check_count;
    logic [15:0] lfsr;
    word_t       model_regs [32];

    id_stage i_dut (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .stall_id  (stall_id),
        .stall_ex  (stall_ex),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .wb_write  (wb_write),
        .ex_load   (ex_load),
        .id_ex     (id_ex),
        .branch    (branch),
        .stall_req (stall_req)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: got %08h, expected %08h at %0t", name, actual, expected, $time);
        end
    endtask

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] funct);
        return {op_special, rs, rt, rd, sa, funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t branch_inst(input int k, input reg_addr_t rs, input reg_addr_t rt,
                                          input logic [15:0] off, input logic [25:0] idx);
        case (k)
            0:       return {op_beq, rs, rt, off};
            1:       return {op_bne, rs, rt, off};
            2:       return {op_blez, rs, 5'd0, off};
            3:       return {op_bgtz, rs, 5'd0, off};
            4:       return {op_regimm, rs, rt_bltz, off};
            5:       return {op_regimm, rs, rt_bgez, off};
            6:       return {op_regimm, rs, rt_bltzal, off};
            7:       return {op_regimm, rs, rt_bgezal, off};
            8:       return {op_j, idx};
            9:       return {op_jal, idx};
            10:      return {op_special, rs, 15'd0, fn_jr};
            default: return {op_special, rs, 5'd0, 5'd31, 5'd0, fn_jalr};
        endcase
    endfunction

    task automatic to_drive_point;
        @(posedge clk);
        #10;
    endtask

    // latch loads at the next edge, outputs read just before the one after
    task automatic sample_next_cycle;
        @(posedge clk);
        #90;
    endtask

    task automatic sample_now;
        #80;
    endtask

    task automatic present(input word_t pc, input word_t inst);
        fetch.ce   = 1'b1;
        fetch.pc   = pc;
        fetch.inst = inst;
    endtask

    task automatic run_reset;
        rst = 1'b1;
        // live jal on fetch while reset holds the latch
        present(32'h0000_0100, {op_jal, 26'h000_0040});
        repeat (5) @(posedge clk);
        #10;
        rst   = 1'b0;
        fetch = '0;
        sample_now();
        check_value("id_ex.rf_we", id_ex.rf_we, 1'b0);
        check_value("id_ex.mem_en", id_ex.mem_en, 1'b0);
        check_value("branch.taken", branch.taken, 1'b0);
        check_value("stall_req", stall_req, 1'b0);
        to_drive_point();
    endtask

    task automatic decode_formats;
        dec_row_t rows [7];
        word_t    pc;
        rows[0] = '{r_type(5'd3, 5'd4, 5'd5, 5'd0, fn_addu),
                    alu_add, src1_rs, src2_rt, 1'b1, 5'd5, 1'b0, 4'h0, 1'b0};
        rows[1] = '{i_type(op_ori, 5'd3, 5'd6, 16'h00f0),
                    alu_or, src1_rs, src2_imm_zero, 1'b1, 5'd6, 1'b0, 4'h0, 1'b0};
        rows[2] = '{i_type(op_lui, 5'd0, 5'd7, 16'h1234),
                    alu_lui, src1_none, src2_imm_sign, 1'b1, 5'd7, 1'b0, 4'h0, 1'b0};
        rows[3] = '{r_type(5'd0, 5'd4, 5'd9, 5'd3, fn_sll),
                    alu_sll, src1_shamt, src2_rt, 1'b1, 5'd9, 1'b0, 4'h0, 1'b0};
        rows[4] = '{i_type(op_lw, 5'd3, 5'd10, 16'hfffc),
                    alu_add, src1_rs, src2_imm_sign, 1'b1, 5'd10, 1'b1, 4'h0, 1'b1};
        rows[5] = '{i_type(op_sw, 5'd3, 5'd11, 16'h0008),
                    alu_add, src1_rs, src2_imm_sign, 1'b0, 5'd0, 1'b1, 4'hf, 1'b0};
        rows[6] = '{i_type(op_slti, 5'd3, 5'd12, 16'h8001),
                    alu_slt, src1_rs, src2_imm_sign, 1'b1, 5'd12, 1'b0, 4'h0, 1'b0};
        for (int i = 0; i < 7; i++) begin
            pc = {30'(take_bits(30)), 2'b00};
            present(pc, rows[i].inst);
            sample_next_cycle();
            check_value("id_ex.pc", id_ex.pc, pc);
            check_value("id_ex.inst", id_ex.inst, rows[i].inst);
            check_value("id_ex.alu_op", id_ex.alu_op, rows[i].alu);
            check_value("id_ex.src1_sel", id_ex.src1_sel, rows[i].s1);
            check_value("id_ex.src2_sel", id_ex.src2_sel, rows[i].s2);
            check_value("id_ex.rf_we", id_ex.rf_we, rows[i].we);
            check_value("id_ex.rf_waddr", id_ex.rf_waddr, rows[i].waddr);
            check_value("id_ex.mem_en", id_ex.mem_en, rows[i].men);
            check_value("id_ex.mem_wen", id_ex.mem_wen, rows[i].wen);
            check_value("id_ex.load_result", id_ex.load_result, rows[i].lr);
            to_drive_point();
        end
    endtask

    task automatic read_operands;
        word_t     value;
        reg_addr_t a;
        reg_addr_t b;
        word_t     fa;
        word_t     fm;
        word_t     fw;
        for (int r = 1; r < 32; r++) begin
            value         = take_bits(32);
            wb_write      = '{we: 1'b1, addr: reg_addr_t'(r), data: value};
            model_regs[r] = value;
            to_drive_point();
        end
        // r0 never stores
        wb_write = '{we: 1'b1, addr: 5'd0, data: take_bits(32)};
        to_drive_point();
        wb_write = '0;
        for (int i = 0; i < 8; i++) begin
            a = 5'(take_bits(5));
            b = 5'(take_bits(5));
            present({30'(take_bits(30)), 2'b00}, r_type(a, b, 5'd1, 5'd0, fn_addu));
            sample_next_cycle();
            check_value("id_ex.rdata1", id_ex.rdata1, model_regs[a]);
            check_value("id_ex.rdata2", id_ex.rdata2, model_regs[b]);
            to_drive_point();
        end
        fa = take_bits(32);
        fm = take_bits(32);
        fw = take_bits(32);
        present(32'h0000_0400, r_type(5'd5, 5'd6, 5'd1, 5'd0, fn_addu));
        ex_fwd  = '{we: 1'b1, addr: 5'd5, data: fa};
        mem_fwd = '{we: 1'b1, addr: 5'd5, data: fm};
        wb_fwd  = '{we: 1'b1, addr: 5'd5, data: fw};
        sample_next_cycle();
        check_value("id_ex.rdata1", id_ex.rdata1, fa);
        check_value("id_ex.rdata2", id_ex.rdata2, model_regs[6]);
        to_drive_point();
        ex_fwd.we = 1'b0;
        sample_now();
        check_value("id_ex.rdata1", id_ex.rdata1, fm);
        to_drive_point();
        mem_fwd.addr = 5'd6;
        sample_now();
        check_value("id_ex.rdata1", id_ex.rdata1, fw);
        check_value("id_ex.rdata2", id_ex.rdata2, fm);
        to_drive_point();
        mem_fwd = '0;
        wb_fwd  = '0;
        sample_now();
        check_value("id_ex.rdata1", id_ex.rdata1, model_regs[5]);
        to_drive_point();
        present(32'h0000_0404, r_type(5'd0, 5'd0, 5'd1, 5'd0, fn_addu));
        ex_fwd  = '{we: 1'b1, addr: 5'd0, data: fa};
        mem_fwd = '{we: 1'b1, addr: 5'd0, data: fm};
        sample_next_cycle();
        check_value("id_ex.rdata1", id_ex.rdata1, 32'd0);
        check_value("id_ex.rdata2", id_ex.rdata2, 32'd0);
        to_drive_point();
        ex_fwd  = '0;
        mem_fwd = '0;
    endtask

    task automatic resolve_branches;
        word_t       pc;
        word_t       v1;
        word_t       v2;
        word_t       rv1;
        word_t       pc4;
        word_t       rel;
        word_t       exp_target;
        logic        exp_taken;
        logic [15:0] off;
        logic [25:0] idx;
        reg_addr_t   rs_a;
        for (int k = 0; k < 12; k++) begin
            for (int t = 0; t < 3; t++) begin
                v1 = take_bits(32);
                v2 = (t == 1) ? v1 : take_bits(32);
                // third trial reads r0 as the first operand
                rs_a = (t == 2) ? 5'd0 : 5'd8;
                rv1  = (t == 2) ? 32'd0 : v1;
                wb_write = '{we: 1'b1, addr: 5'd8, data: v1};
                model_regs[8] = v1;
                to_drive_point();
                wb_write = '{we: 1'b1, addr: 5'd9, data: v2};
                model_regs[9] = v2;
                to_drive_point();
                wb_write = '0;
                pc  = {30'(take_bits(30)), 2'b00};
                off = 16'(take_bits(16));
                idx = 26'(take_bits(26));
                present(pc, branch_inst(k, rs_a, 5'd9, off, idx));
                sample_next_cycle();
                pc4 = pc + 32'd4;
                rel = pc4 + {{14{off[15]}}, off, 2'b00};
                exp_target = rel;
                case (k)
                    0:       exp_taken = (rv1 == v2);
                    1:       exp_taken = (rv1 != v2);
                    2:       exp_taken = rv1[31] || (rv1 == 32'd0);
                    3:       exp_taken = !rv1[31] && (rv1 != 32'd0);
                    4, 6:    exp_taken = rv1[31];
                    5, 7:    exp_taken = !rv1[31];
                    8, 9: begin
                        exp_taken  = 1'b1;
                        exp_target = {pc4[31:28], idx, 2'b00};
                    end
                    default: begin
                        exp_taken  = 1'b1;
                        exp_target = rv1;
                    end
                endcase
                check_value("branch.taken", branch.taken, exp_taken);
                check_value("branch.target", branch.target, exp_target);
                if (k == 6 || k == 7 || k == 9 || k == 11) begin
                    check_value("id_ex.rf_waddr", id_ex.rf_waddr, 32'd31);
                end
                to_drive_point();
            end
        end
    endtask

    task automatic hold_and_bubble;
        word_t pc_a;
        word_t pc_b;
        word_t pc_c;
        pc_a = {30'(take_bits(30)), 2'b00};
        pc_b = {30'(take_bits(30)), 2'b00};
        pc_c = {30'(take_bits(30)), 2'b00};
        present(pc_a, r_type(5'd3, 5'd4, 5'd5, 5'd0, fn_addu));
        sample_next_cycle();
        check_value("id_ex.pc", id_ex.pc, pc_a);
        to_drive_point();
        stall_id = 1'b1;
        stall_ex = 1'b1;
        present(pc_b, i_type(op_ori, 5'd3, 5'd6, 16'h1234));
        sample_next_cycle();
        check_value("id_ex.pc", id_ex.pc, pc_a);
        to_drive_point();
        present(pc_c, i_type(op_lw, 5'd3, 5'd7, 16'h0010));
        sample_next_cycle();
        check_value("id_ex.pc", id_ex.pc, pc_a);
        to_drive_point();
        stall_ex = 1'b0;
        sample_next_cycle();
        check_value("id_ex.pc", id_ex.pc, 32'd0);
        check_value("id_ex.rf_we", id_ex.rf_we, 1'b0);
        to_drive_point();
        stall_id = 1'b0;
        sample_next_cycle();
        check_value("id_ex.pc", id_ex.pc, pc_c);
        check_value("id_ex.rf_we", id_ex.rf_we, 1'b1);
        to_drive_point();
    endtask

    task automatic load_use_stall;
        reg_addr_t addrs [4];
        logic      loads [4];
        addrs = '{5'd3, 5'd4, 5'd7, 5'd3};
        loads = '{1'b1, 1'b1, 1'b1, 1'b0};
        ex_fwd = '0;
        present(32'h0000_0800, r_type(5'd3, 5'd4, 5'd5, 5'd0, fn_addu));
        sample_next_cycle();
        check_value("stall_req", stall_req, 1'b0);
        to_drive_point();
        for (int i = 0; i < 4; i++) begin
            ex_load     = loads[i];
            ex_fwd.addr = addrs[i];
            sample_now();
            check_value("stall_req", stall_req,
                        loads[i] && (addrs[i] == 5'd3 || addrs[i] == 5'd4));
            to_drive_point();
        end
        ex_load = 1'b0;
        ex_fwd  = '0;
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        lfsr        = 16'd76;
        rst         = 1'b1;
        fetch       = '0;
        stall_id    = 1'b0;
        stall_ex    = 1'b0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        wb_fwd      = '0;
        wb_write    = '0;
        ex_load     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        run_reset();
        decode_formats();
        read_operands();
        resolve_branches();
        hold_and_bubble();
        load_use_stall();
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(total_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", total_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* list.f */
decode_pkg.sv
decode_latch.sv
inst_decoder.sv
operand_read.sv
branch_resolve.sv
id_stage.sv
tb_id_stage.sv
